// File: verilog/spi_cfg_pkg.sv
// Frame widths, register vector types and sequencer states for the SPI config path
package spi_cfg_pkg;

    // Register address and value widths
    localparam int ADDR_W = 6;
    localparam int DATA_W = 32;

    // One SPI frame carries the address on top of the value
    localparam int FRAME_W = ADDR_W + DATA_W;

    // Register address as written by the host
    typedef logic [ADDR_W-1:0] cfg_addr_t;

    // Register value as written by the host
    typedef logic [DATA_W-1:0] cfg_data_t;

    // Packed frame, address in bits 37..32, value in bits 31..0
    typedef logic [FRAME_W-1:0] spi_frame_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_START = 2'd1,
        SEQ_SHIFT = 2'd2,
        SEQ_GAP   = 2'd3
    } seq_state_t;

endpackage

// File: verilog/cfg_frame_fifo.sv
// Circular queue of packed configuration frames with full and empty flags
module cfg_frame_fifo
    import spi_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic       host_clk,
    input  logic       host_rst,

    // Write side
    input  logic       wr,
    input  spi_frame_t wr_frame,

    // Read side
    input  logic       pop,
    output spi_frame_t head_frame,

    output logic       empty,
    output logic       full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Pointers carry one extra bit to tell full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    spi_frame_t mem [FIFO_DEPTH];

    logic wr_en;

    assign wr_en = wr && !full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign head_frame = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge host_clk or posedge host_rst) begin
        if (host_rst) begin
            wr_ptr <= '0;
        end
        else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Pop is only raised when the queue holds a frame
    always_ff @(posedge host_clk or posedge host_rst) begin
        if (host_rst) begin
            rd_ptr <= '0;
        end
        else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_frame;
        end
    end

endmodule

// File: verilog/spi_cfg_sequencer.sv
// FSM that pops frames, starts the serializer, waits for done and holds the chip-select gap
module spi_cfg_sequencer
    import spi_cfg_pkg::*;
#(
    parameter int CSN_GAP = 4
)(
    input  logic       host_clk,
    input  logic       host_rst,

    // Queue side
    input  logic       fifo_empty,
    input  spi_frame_t fifo_frame,
    output logic       fifo_pop,

    // Serializer side
    output logic       tx_start,
    output spi_frame_t tx_frame,
    input  logic       tx_done,

    output logic       busy
);

    localparam int GAP_W = $clog2(CSN_GAP + 1);

    seq_state_t state;

    logic [GAP_W-1:0] gap_cnt;

    assign fifo_pop = (state == SEQ_IDLE) && !fifo_empty;
    assign tx_start = (state == SEQ_START);
    assign busy     = (state != SEQ_IDLE);

    always_ff @(posedge host_clk or posedge host_rst) begin
        if (host_rst) begin
            state   <= SEQ_IDLE;
            gap_cnt <= '0;
        end
        else begin
            case (state)
                SEQ_IDLE: begin
                    if (!fifo_empty) begin
                        state <= SEQ_START;
                    end
                end
                SEQ_START: begin
                    state <= SEQ_SHIFT;
                end
                SEQ_SHIFT: begin
                    if (tx_done) begin
                        state   <= SEQ_GAP;
                        gap_cnt <= GAP_W'(CSN_GAP - 1);
                    end
                end
                SEQ_GAP: begin
                    // Chip select stays high for CSN_GAP cycles here
                    if (gap_cnt == '0) begin
                        state <= SEQ_IDLE;
                    end
                    else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Head frame is captured on the pop
    always_ff @(posedge host_clk) begin
        if (fifo_pop) begin
            tx_frame <= fifo_frame;
        end
    end

endmodule

// File: verilog/spi_frame_tx.sv
// SPI mode 0 serializer shifting one frame MSB first, SCLK at half of host_clk
module spi_frame_tx
    import spi_cfg_pkg::*;
(
    input  logic       host_clk,
    input  logic       host_rst,

    // Frame request
    input  logic       start,
    input  spi_frame_t frame,
    output logic       done,

    // SPI pins
    output logic       spi_clk,
    output logic       spi_csn,
    output logic       spi_mosi
);

    localparam int CNT_W = $clog2(FRAME_W);

    // Bits still waiting behind the one on MOSI
    spi_frame_t       shift_reg;
    logic [CNT_W-1:0] bit_cnt;

    logic in_flight;
    logic load;
    logic next_bit;

    assign in_flight = !spi_csn;
    assign load      = start && !in_flight;

    // End of a high phase moves on to the next bit
    assign next_bit  = in_flight && spi_clk && (bit_cnt != '0);

    always_ff @(posedge host_clk or posedge host_rst) begin
        if (host_rst) begin
            spi_csn  <= 1'b1;
            spi_clk  <= 1'b0;
            spi_mosi <= 1'b0;
            bit_cnt  <= '0;
            done     <= 1'b0;
        end
        else begin
            done <= 1'b0;
            if (load) begin
                spi_csn  <= 1'b0;
                spi_clk  <= 1'b0;
                spi_mosi <= frame[FRAME_W-1];
                bit_cnt  <= CNT_W'(FRAME_W - 1);
            end
            else if (in_flight) begin
                if (!spi_clk) begin
                    // Slave samples on this rising edge
                    spi_clk <= 1'b1;
                end
                else if (next_bit) begin
                    spi_clk  <= 1'b0;
                    spi_mosi <= shift_reg[FRAME_W-1];
                    bit_cnt  <= bit_cnt - 1'b1;
                end
                else begin
                    // Last high phase done, release the slave
                    spi_clk  <= 1'b0;
                    spi_csn  <= 1'b1;
                    spi_mosi <= 1'b0;
                    done     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (load) begin
            shift_reg <= frame << 1;
        end
        else if (next_bit) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

// File: verilog/spi_cfg_top.sv
// Top level packing address and value into frames and wiring queue, sequencer and serializer
module spi_cfg_top
    import spi_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int CSN_GAP    = 4
)(
    input  logic      host_clk,
    input  logic      host_rst,

    // Host write port
    input  logic      cfg_wr,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_data,
    output logic      cfg_full,
    output logic      cfg_busy,

    // SPI pins
    output logic      spi_clk,
    output logic      spi_csn,
    output logic      spi_mosi
);

    spi_frame_t wr_frame;
    spi_frame_t fifo_frame;
    spi_frame_t tx_frame;

    logic fifo_empty;
    logic fifo_pop;
    logic tx_start;
    logic tx_done;
    logic seq_busy;

    // Address goes out first
    assign wr_frame = {cfg_addr, cfg_data};

    assign cfg_busy = !fifo_empty || seq_busy;

    cfg_frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) cfg_frame_fifo_i (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .wr         (cfg_wr),
        .wr_frame   (wr_frame),
        .pop        (fifo_pop),
        .head_frame (fifo_frame),
        .empty      (fifo_empty),
        .full       (cfg_full)
    );

    spi_cfg_sequencer #(
        .CSN_GAP (CSN_GAP)
    ) spi_cfg_sequencer_i (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .fifo_empty (fifo_empty),
        .fifo_frame (fifo_frame),
        .fifo_pop   (fifo_pop),
        .tx_start   (tx_start),
        .tx_frame   (tx_frame),
        .tx_done    (tx_done),
        .busy       (seq_busy)
    );

    spi_frame_tx spi_frame_tx_i (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .start    (tx_start),
        .frame    (tx_frame),
        .done     (tx_done),
        .spi_clk  (spi_clk),
        .spi_csn  (spi_csn),
        .spi_mosi (spi_mosi)
    );

endmodule

// File: test/spi_frame_capture.sv
// Passive SPI slave model reporting each received frame with its bit count and chip-select timing
module spi_frame_capture
    import spi_cfg_pkg::*;
(
    input  logic        host_clk,
    input  logic        host_rst,
    input  logic        spi_clk,
    input  logic        spi_csn,
    input  logic        spi_mosi,
    output logic        frame_valid,
    output spi_frame_t  frame_data,
    output logic [31:0] bit_count,
    output logic [31:0] low_cycles,
    output logic [31:0] gap_cycles,
    output logic        first_frame
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        prev_clk;
    logic        prev_csn;
    spi_frame_t  shift;
    logic [31:0] bits;
    logic [31:0] low_cnt;
    logic [31:0] high_cnt;
    logic [31:0] gap_before;
    logic [31:0] frame_cnt;

    // Pins are sampled on host_clk, so a rising spi_clk shows up as a 0 to 1 step
    always @(posedge host_clk or posedge host_rst) begin
        if (host_rst) begin
            prev_clk    <= 1'b0;
            prev_csn    <= 1'b1;
            shift       <= '0;
            bits        <= '0;
            low_cnt     <= '0;
            high_cnt    <= '0;
            gap_before  <= '0;
            frame_cnt   <= '0;
            frame_valid <= 1'b0;
            frame_data  <= '0;
            bit_count   <= '0;
            low_cycles  <= '0;
            gap_cycles  <= '0;
            first_frame <= 1'b0;
        end
        else begin
            prev_clk    <= spi_clk;
            prev_csn    <= spi_csn;
            frame_valid <= 1'b0;
            if (!spi_csn && prev_csn) begin
                // Chip select fell, new frame
                gap_before <= high_cnt;
                low_cnt    <= 32'd1;
                shift      <= '0;
                bits       <= '0;
            end
            else if (!spi_csn) begin
                low_cnt <= low_cnt + 1;
                if (spi_clk && !prev_clk) begin
                    shift <= {shift[FRAME_W-2:0], spi_mosi};
                    bits  <= bits + 1;
                end
            end
            else if (!prev_csn) begin
                // Chip select rose, frame complete
                frame_valid <= 1'b1;
                frame_data  <= shift;
                bit_count   <= bits;
                low_cycles  <= low_cnt;
                gap_cycles  <= gap_before;
                first_frame <= (frame_cnt == 0);
                frame_cnt   <= frame_cnt + 1;
                high_cnt    <= 32'd1;
            end
            else begin
                high_cnt <= high_cnt + 1;
            end
        end
    end

endmodule

// File: test/spi_cfg_tb.sv
// Testbench for the SPI config path with clock, reset, stimulus, reference frames and scoreboard
module spi_cfg_tb
    import spi_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH     = 4;
    localparam int CSN_GAP        = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int WAIT_LIMIT     = 2000;
    localparam int BITS_PER_FRAME = 38;
    localparam int CSN_LOW_CYCLES = 76;

    logic      host_clk;
    logic      host_rst;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      cfg_full;
    logic      cfg_busy;
    logic      spi_clk;
    logic      spi_csn;
    logic      spi_mosi;

    logic        frame_valid;
    spi_frame_t  frame_data;
    logic [31:0] bit_count;
    logic [31:0] low_cycles;
    logic [31:0] gap_cycles;
    logic        first_frame;

    // Frames of accepted writes in arrival order
    spi_frame_t expected_q[$];

    integer seed         = 32'h01cd_d7a0;
    int     error_cnt    = 0;
    int     timeout_cnt  = 0;
    int     frames_seen  = 0;
    int     accepted_cnt = 0;
    int     refused_cnt  = 0;

    spi_cfg_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CSN_GAP    (CSN_GAP)
    ) spi_cfg_top_i (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg_full (cfg_full),
        .cfg_busy (cfg_busy),
        .spi_clk  (spi_clk),
        .spi_csn  (spi_csn),
        .spi_mosi (spi_mosi)
    );

    spi_frame_capture spi_frame_capture_i (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .spi_clk     (spi_clk),
        .spi_csn     (spi_csn),
        .spi_mosi    (spi_mosi),
        .frame_valid (frame_valid),
        .frame_data  (frame_data),
        .bit_count   (bit_count),
        .low_cycles  (low_cycles),
        .gap_cycles  (gap_cycles),
        .first_frame (first_frame)
    );

    initial begin
        host_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) host_clk = ~host_clk;
        end
    end

    // Address in bits 37..32, value in bits 31..0
    function automatic spi_frame_t expected_frame(input cfg_addr_t addr, input cfg_data_t data);
        spi_frame_t f;
        f        = '0;
        f[37:32] = addr;
        f[31:0]  = data;
        return f;
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            error_cnt++;
        end
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_seen < target && cycles < WAIT_LIMIT) begin
            @(posedge host_clk);
            #1;
            cycles++;
        end
        if (frames_seen < target) begin
            $display("Timed out after %0d cycles waiting for SPI frame %0d", WAIT_LIMIT, target);
            timeout_cnt++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (cfg_busy && cycles < WAIT_LIMIT) begin
            @(posedge host_clk);
            #1;
            cycles++;
        end
        if (cfg_busy) begin
            $display("Timed out after %0d cycles waiting for cfg_busy to drop", WAIT_LIMIT);
            timeout_cnt++;
        end
    endtask

    // A write counts when cfg_wr is high and cfg_full low at the edge
    initial begin : accept_monitor
        forever begin
            @(negedge host_clk);
            if (!host_rst && cfg_wr) begin
                if (!cfg_full) begin
                    expected_q.push_back(expected_frame(cfg_addr, cfg_data));
                    accepted_cnt++;
                end
                else begin
                    refused_cnt++;
                end
            end
        end
    end

    initial begin : compare_frames
        spi_frame_t exp;
        forever begin
            @(negedge host_clk);
            if (frame_valid) begin
                frames_seen++;
                assert (expected_q.size() > 0) else begin
                    $display("Frame 0x%h came out on SPI with no accepted write left", frame_data);
                    error_cnt++;
                end
                if (expected_q.size() > 0) begin
                    exp = expected_q.pop_front();
                    assert (bit_count == BITS_PER_FRAME) else begin
                        $display("ERROR bit_count: expected 0x%h, got 0x%h",
                                 BITS_PER_FRAME, bit_count);
                        error_cnt++;
                    end
                    assert (frame_data === exp) else begin
                        $display("ERROR spi_mosi frame: expected 0x%h, got 0x%h", exp, frame_data);
                        error_cnt++;
                    end
                    assert (low_cycles == CSN_LOW_CYCLES) else begin
                        $display("ERROR spi_csn low cycles: expected 0x%h, got 0x%h",
                                 CSN_LOW_CYCLES, low_cycles);
                        error_cnt++;
                    end
                    assert (first_frame || gap_cycles >= CSN_GAP + 2) else begin
                        $display("ERROR spi_csn gap: expected at least 0x%h, got 0x%h",
                                 CSN_GAP + 2, gap_cycles);
                        error_cnt++;
                    end
                end
            end
        end
    end

    initial begin : main_flow
        logic [31:0] rnd;
        int          i;
        host_rst = 1'b1;
        cfg_wr   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        repeat (2) @(posedge host_clk);
        #1;
        host_rst = 1'b0;

        // Idle levels straight out of reset
        @(negedge host_clk);
        check_level("spi_csn", spi_csn, 1'b1);
        check_level("spi_clk", spi_clk, 1'b0);
        check_level("cfg_full", cfg_full, 1'b0);
        check_level("cfg_busy", cfg_busy, 1'b0);
        @(posedge host_clk);
        #1;

        // Single write
        rnd      = $random(seed);
        cfg_addr = rnd[5:0];
        cfg_data = $random(seed);
        cfg_wr   = 1'b1;
        @(posedge host_clk);
        #1;
        cfg_wr = 1'b0;
        // Queue holds the frame now
        check_level("cfg_busy", cfg_busy, 1'b1);
        wait_frames(1);
        wait_idle();

        // Burst longer than the queue so that some writes bounce
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            // The sequencer takes the first frame, so only the last write meets a full queue
            check_level("cfg_full", cfg_full, i == FIFO_DEPTH + 1);
            rnd      = $random(seed);
            cfg_addr = rnd[5:0];
            cfg_data = $random(seed);
            cfg_wr   = 1'b1;
            @(posedge host_clk);
            #1;
        end
        cfg_wr = 1'b0;
        assert (refused_cnt > 0) else begin
            $display("No write was refused during a burst of %0d writes", FIFO_DEPTH + 2);
            error_cnt++;
        end
        wait_frames(accepted_cnt);
        wait_idle();

        // Bus must stay quiet once the queue drains
        repeat (20) begin
            @(negedge host_clk);
            check_level("spi_clk", spi_clk, 1'b0);
            check_level("spi_csn", spi_csn, 1'b1);
            check_level("cfg_busy", cfg_busy, 1'b0);
        end
        assert (expected_q.size() == 0) else begin
            $display("%0d accepted writes never came out on SPI", expected_q.size());
            error_cnt++;
        end
        assert (frames_seen == accepted_cnt) else begin
            $display("ERROR frame count: expected 0x%h, got 0x%h", accepted_cnt, frames_seen);
            error_cnt++;
        end

        $display("Frames: %0d, accepted: %0d, refused: %0d, errors: %0d, timeouts: %0d",
                 frames_seen, accepted_cnt, refused_cnt, error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/spi_cfg_pkg.sv
verilog/cfg_frame_fifo.sv
verilog/spi_cfg_sequencer.sv
verilog/spi_frame_tx.sv
verilog/spi_cfg_top.sv
test/spi_frame_capture.sv
test/spi_cfg_tb.sv

// File: Bender.yml
package:
  name: spi_cfg

sources:
  # RTL
  - verilog/spi_cfg_pkg.sv
  - verilog/cfg_frame_fifo.sv
  - verilog/spi_cfg_sequencer.sv
  - verilog/spi_frame_tx.sv
  - verilog/spi_cfg_top.sv

  # Testbench
  - target: test
    files:
      - test/spi_frame_capture.sv
      - test/spi_cfg_tb.sv
